// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := la_core_tb
FILELIST  := la_core.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== la_capture.sv ====
/* ring-buffer writer, armed by arm_i and stopped by the delay count
   the write holding the trigger sample is granted in the run cycle,
   which holds while capture has top priority at the memory */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_capture import la_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        arm_i,
  input  logic        armed_i,
  input  logic        run_i,
  input  logic        set_count_i,
  input  logic [15:0] delay_i,
  input  la_sample_t  sample_i,
  input  logic        sample_stb_i,
  input  logic        gnt_i,
  output logic        req_o,
  output la_mem_req_t mem_req_o,
  output logic        done_o,
  output la_addr_t    last_addr_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_PRE, ST_POST} cap_state_t;

  cap_state_t  state_q;
  la_addr_t    wptr_q;
  la_addr_t    last_q;        // address of the newest granted write
  logic [15:0] delay_q;
  logic [15:0] cnt_q;
  logic        take;
  logic        finish;

  always_comb begin
    take = 1'b0;
    case (state_q)
      ST_PRE:  take = sample_stb_i && (armed_i || (run_i && delay_q != 16'd0));
      ST_POST: take = sample_stb_i && (cnt_q != 16'd0);
      default: take = 1'b0;
    endcase
  end

  assign finish = (state_q == ST_POST) && !take && (cnt_q == 16'd0) && (!req_o || gnt_i);

  // payload side, written address and data
  always_ff @(posedge clk_i) begin
    if (take) mem_req_o <= '{we: 1'b1, addr: wptr_q, wdata: sample_i};
    if (req_o && gnt_i) last_q <= mem_req_o.addr;
    if (finish) last_addr_o <= req_o ? mem_req_o.addr : last_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      wptr_q  <= '0;
      delay_q <= '0;
      cnt_q   <= '0;
      req_o   <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      done_o <= finish;
      if (set_count_i) delay_q <= delay_i;
      if (take) begin
        req_o  <= 1'b1;
        wptr_q <= wptr_q + 1'b1;
      end else if (gnt_i) begin
        req_o <= 1'b0;          // held until granted
      end
      case (state_q)
        ST_IDLE: if (arm_i) state_q <= ST_PRE;
        ST_PRE: if (run_i) begin
          state_q <= ST_POST;
          cnt_q   <= delay_q - {15'd0, take};
        end
        ST_POST: begin
          if (take) cnt_q <= cnt_q - 16'd1;
          else if (finish) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // no memory write lands while the writer sits idle
  a_no_idle_write: assert property (@(posedge clk_i) disable iff (rst_i)
    req_o && gnt_i |-> $past(state_q != ST_IDLE))
    else $error("capture wrote while idle");

endmodule

// ==== la_cmd_decoder.sv ====
/* command decoder, one registered pulse per known opcode
   pulses come one clock after exec_i, unknown opcodes are dropped
   the argument is not stored here, receivers take it from cmd_i */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_cmd_decoder import la_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    exec_i,        // one-cycle execute strobe
  input  la_cmd_t cmd_i,
  output logic    soft_rst_o,
  output logic    arm_o,
  output logic    set_mask_o,
  output logic    set_value_o,
  output logic    set_div_o,
  output logic    set_count_o
);

  logic [7:0] opc;

  assign opc = cmd_i.opcode;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      soft_rst_o  <= 1'b0;
      arm_o       <= 1'b0;
      set_mask_o  <= 1'b0;
      set_value_o <= 1'b0;
      set_div_o   <= 1'b0;
      set_count_o <= 1'b0;
    end else begin
      soft_rst_o  <= exec_i && (opc == `LA_OPC_RESET);
      arm_o       <= exec_i && (opc == `LA_OPC_ARM);
      set_mask_o  <= exec_i && (opc == `LA_OPC_MASK);
      set_value_o <= exec_i && (opc == `LA_OPC_VALUE);
      set_div_o   <= exec_i && (opc == `LA_OPC_DIV);
      set_count_o <= exec_i && (opc == `LA_OPC_COUNT);
    end
  end

  // a single command never fans out to two blocks
  a_one_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({soft_rst_o, arm_o, set_mask_o, set_value_o, set_div_o, set_count_o}))
    else $error("decoder raised more than one command pulse");

endmodule

// ==== la_consts.svh ====
/* shared constants of the logic analyzer core
   LA_DEPTH is an address width, the memory holds 2**LA_DEPTH samples
   opcodes follow the SUMP numbering, only the subset handled here */
`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

`define LA_SW     32      // sample width
`define LA_DEPTH  5       // address bits, 32 words

`define LA_OPC_RESET  8'h00
`define LA_OPC_ARM    8'h01
`define LA_OPC_MASK   8'hC0   // trigger mask
`define LA_OPC_VALUE  8'hC1   // trigger value
`define LA_OPC_DIV    8'h80   // sample divider
`define LA_OPC_COUNT  8'h81   // read and delay counts

`endif

// ==== la_core.f ====
+incdir+.
la_pkg.sv
la_cmd_decoder.sv
la_sampler.sv
la_trigger.sv
la_capture.sv
la_readout.sv
la_sample_mem.sv
la_core.sv
tb_clkgen.sv
la_core_tb.sv

// ==== la_core.sv ====
/* top level of the logic analyzer core
   cmd_i has to stay stable for the clock after exec_i,
   the blocks take the argument one clock after the strobe
   rst_o is high for hardware reset and for the one-clock soft reset */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_core import la_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       exec_i,       // execute command
  input  la_cmd_t    cmd_i,
  input  la_sample_t input_i,      // probed signals
  input  logic       tx_rdy_i,     // transmitter ready flag
  output logic       rst_o,
  output logic       tx_stb_o,
  output la_sample_t tx_o
);

  logic        rst;
  logic        soft_rst;
  logic        arm;
  logic        set_mask;
  logic        set_value;
  logic        set_div;
  logic        set_count;
  la_sample_t  sample;
  logic        sample_stb;
  logic        armed;
  logic        run;
  logic        cap_req;
  logic        cap_gnt;
  la_mem_req_t cap_mem;
  logic        cap_done;
  la_addr_t    last_addr;
  logic        rd_req;
  logic        rd_gnt;
  la_mem_req_t rd_mem;
  la_sample_t  rdata;

  assign rst   = rst_i || soft_rst;
  assign rst_o = rst;

  la_cmd_decoder u_decoder (
    .clk_i(clk_i), .rst_i(rst), .exec_i(exec_i), .cmd_i(cmd_i),
    .soft_rst_o(soft_rst), .arm_o(arm), .set_mask_o(set_mask),
    .set_value_o(set_value), .set_div_o(set_div), .set_count_o(set_count)
  );

  la_sampler u_sampler (
    .clk_i(clk_i), .rst_i(rst), .set_div_i(set_div), .div_i(cmd_i.arg[23:0]),
    .data_i(input_i), .sample_o(sample), .sample_stb_o(sample_stb)
  );

  la_trigger u_trigger (
    .clk_i(clk_i), .rst_i(rst), .arm_i(arm), .set_mask_i(set_mask),
    .set_value_i(set_value), .arg_i(cmd_i.arg), .sample_i(sample),
    .sample_stb_i(sample_stb), .armed_o(armed), .run_o(run)
  );

  la_capture u_capture (
    .clk_i(clk_i), .rst_i(rst), .arm_i(arm), .armed_i(armed), .run_i(run),
    .set_count_i(set_count), .delay_i(cmd_i.arg[31:16]), .sample_i(sample),
    .sample_stb_i(sample_stb), .gnt_i(cap_gnt), .req_o(cap_req),
    .mem_req_o(cap_mem), .done_o(cap_done), .last_addr_o(last_addr)
  );

  la_readout u_readout (
    .clk_i(clk_i), .rst_i(rst), .set_count_i(set_count),
    .read_count_i(cmd_i.arg[15:0]), .done_i(cap_done), .last_addr_i(last_addr),
    .gnt_i(rd_gnt), .rdata_i(rdata), .tx_rdy_i(tx_rdy_i), .req_o(rd_req),
    .mem_req_o(rd_mem), .tx_stb_o(tx_stb_o), .tx_o(tx_o)
  );

  la_sample_mem u_mem (
    .clk_i(clk_i), .cap_req_i(cap_req), .cap_i(cap_mem), .rd_req_i(rd_req),
    .rd_i(rd_mem), .cap_gnt_o(cap_gnt), .rd_gnt_o(rd_gnt), .rdata_o(rdata)
  );

endmodule

// ==== la_core_tb.sv ====
/* testbench for the logic analyzer core
   input_i is a free-running counter, so every captured word is predictable
   commands and the transmitter ready flag change on falling edges
   trigger values are chosen far enough ahead that the ring is filled first */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_core_tb import la_pkg::*; ();

  logic       clk;
  logic       rst;
  logic       exec;
  la_cmd_t    cmd;
  la_sample_t input_word = '0;
  logic       tx_rdy;
  logic       dut_rst;
  logic       tx_stb;
  la_sample_t tx_word;

  int         err_cnt = 0;
  int         to_cnt = 0;
  bit         bp_on = 1'b0;      // random back-pressure
  bit         quiet = 1'b0;      // window with no strobe and no reset
  bit         chk_first = 1'b0;
  la_sample_t exp_first;
  la_sample_t exp_step;          // distance between adjacent words
  la_sample_t words[$];          // words seen on tx_o

  tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

  la_core u_la_core (
    .clk_i(clk), .rst_i(rst), .exec_i(exec), .cmd_i(cmd), .input_i(input_word),
    .tx_rdy_i(tx_rdy), .rst_o(dut_rst), .tx_stb_o(tx_stb), .tx_o(tx_word)
  );

  always @(negedge clk) input_word <= input_word + 32'd1;   // probed counter

  // transmitter model, ready always high or randomly low
  initial begin
    void'($urandom(12));
    tx_rdy = 1'b1;
    forever begin
      @(negedge clk);
      tx_rdy = bp_on ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  // scoreboard, newest first so each word steps down
  always @(posedge clk) begin
    if (!rst && tx_stb) begin
      if (words.size() == 0) begin
        if (chk_first) begin
          assert (tx_word == exp_first) else begin
            err_cnt = err_cnt + 1;
            $display("Mismatch at %0t: first word %h, expected %h", $time, tx_word, exp_first);
          end
        end
      end else begin
        assert (tx_word == words[$] - exp_step) else begin
          err_cnt = err_cnt + 1;
          $display("Mismatch at %0t: word %0d is %h, expected %h", $time, words.size(),
                   tx_word, words[$] - exp_step);
        end
      end
      words.push_back(tx_word);
    end
  end

  a_stb_with_rdy: assert property (@(posedge clk) disable iff (rst) tx_stb |-> tx_rdy)
    else begin
      err_cnt = err_cnt + 1;
      $display("at %0t a word was strobed while the transmitter was not ready", $time);
    end

  // soft reset pulse one clock after the reset command
  a_rst_after_cmd: assert property (@(posedge clk) disable iff (rst)
    exec && cmd.opcode == `LA_OPC_RESET |=> dut_rst)
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: rst_o low one clock after a reset command", $time);
    end

  a_rst_cause: assert property (@(posedge clk) disable iff (rst)
    $rose(dut_rst) |-> $past(exec && cmd.opcode == `LA_OPC_RESET))
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: rst_o rose without a reset command", $time);
    end

  a_rst_width: assert property (@(posedge clk) disable iff (rst) dut_rst |=> !dut_rst)
    else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: rst_o high for more than one clock", $time);
    end

  a_quiet: assert property (@(posedge clk) disable iff (rst) quiet |-> !tx_stb && !dut_rst)
    else begin
      err_cnt = err_cnt + 1;
      $display("at %0t the core strobed or reset while it should stay silent", $time);
    end

  // cmd_i is held one more clock so the blocks can take the argument
  task automatic send_cmd(input logic [7:0] opc, input logic [31:0] arg);
    @(negedge clk);
    cmd  = '{opcode: opc, arg: arg};
    exec = 1'b1;
    @(negedge clk);
    exec = 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_reset_release(input int limit);
    int cycles;
    cycles = 0;
    while (rst && cycles < limit) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (rst) begin
      to_cnt = to_cnt + 1;
      $display("at %0t reset was never released", $time);
    end
  endtask

  task automatic wait_words(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (words.size() < n && cycles < limit) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (words.size() < n) begin
      to_cnt = to_cnt + 1;
      $display("at %0t timed out waiting for %0d words, only %0d arrived",
               $time, n, words.size());
    end
  endtask

  // one capture and readout, expected words follow from the counter
  task automatic capture_run(input logic [23:0] div, input logic [15:0] delay,
                             input logic [15:0] count, input bit full_mask);
    la_sample_t value;
    value = input_word + 32'd40;        // well ahead of the counter
    words.delete();
    chk_first = full_mask;
    exp_first = value + {16'd0, delay};
    exp_step  = {8'd0, div} + 32'd1;
    send_cmd(`LA_OPC_MASK, full_mask ? 32'hFFFF_FFFF : 32'h0);
    send_cmd(`LA_OPC_VALUE, value);
    send_cmd(`LA_OPC_DIV, {8'd0, div});
    send_cmd(`LA_OPC_COUNT, {delay, count});
    send_cmd(`LA_OPC_ARM, 32'd0);
    wait_words(count, 4000);
    repeat (40) @(negedge clk);         // room for a stray extra word
    assert (words.size() == count) else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: %0d words sent, expected %0d", $time, words.size(), count);
    end
  endtask

  initial begin
    exec = 1'b0;
    cmd  = '0;
    wait_reset_release(100);

    // idle core after reset
    quiet = 1'b1;
    repeat (50) @(negedge clk);
    quiet = 1'b0;
    assert (words.size() == 0) else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: %0d words sent without a command", $time, words.size());
    end

    capture_run(24'd0, 16'd0, 16'd8, 1'b1);   // plain trigger match
    capture_run(24'd3, 16'd7, 16'd6, 1'b0);   // divider, mask 0 fires at once
    capture_run(24'd0, 16'd5, 16'd8, 1'b1);   // delay count

    bp_on = 1'b1;
    capture_run(24'd0, 16'd0, 16'd8, 1'b1);
    bp_on = 1'b0;

    // soft reset while armed, value far away so it cannot fire first
    send_cmd(`LA_OPC_MASK, 32'hFFFF_FFFF);
    send_cmd(`LA_OPC_VALUE, input_word + 32'd1000);
    send_cmd(`LA_OPC_COUNT, {16'd0, 16'd4});
    send_cmd(`LA_OPC_ARM, 32'd0);
    send_cmd(`LA_OPC_RESET, 32'd0);
    words.delete();
    quiet = 1'b1;
    send_cmd(`LA_OPC_COUNT, {16'd2, 16'd4});   // zero mask would fire if still armed
    repeat (60) @(negedge clk);
    quiet = 1'b0;
    assert (words.size() == 0) else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: %0d words sent after soft reset", $time, words.size());
    end
    capture_run(24'd0, 16'd0, 16'd8, 1'b1);

    $display("checks done: %0d mismatches or errors, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== la_pkg.sv ====
/* types shared by the logic analyzer blocks
   widths come from la_consts.svh */
`include "la_consts.svh"

package la_pkg;

  typedef logic [`LA_SW-1:0]    la_sample_t;
  typedef logic [`LA_DEPTH-1:0] la_addr_t;

  // 40-bit command word, opcode in the top byte
  typedef struct packed {
    logic [7:0]  opcode;
    logic [31:0] arg;
  } la_cmd_t;

  typedef struct packed {
    la_sample_t mask;    // bits that take part in the match
    la_sample_t value;
  } la_trig_cfg_t;

  // one access to the sample memory
  typedef struct packed {
    logic       we;
    la_addr_t   addr;
    la_sample_t wdata;
  } la_mem_req_t;

endpackage

// ==== la_readout.sv ====
/* readout of the captured samples, newest first
   the word count is capped at the memory size, 0 sends nothing
   tx_rdy_i low stalls the readout with the word held on tx_o */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_readout import la_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        set_count_i,
  input  logic [15:0] read_count_i,
  input  logic        done_i,
  input  la_addr_t    last_addr_i,
  input  logic        gnt_i,
  input  la_sample_t  rdata_i,
  input  logic        tx_rdy_i,
  output logic        req_o,
  output la_mem_req_t mem_req_o,
  output logic        tx_stb_o,
  output la_sample_t  tx_o
);

  localparam int unsigned MEM_WORDS = 1 << `LA_DEPTH;

  typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WAIT, ST_SEND} rd_state_t;

  rd_state_t   state_q;
  la_addr_t    addr_q;
  logic [15:0] count_q;
  logic [15:0] left_q;      // words still to send

  assign req_o     = (state_q == ST_READ);
  assign mem_req_o = '{we: 1'b0, addr: addr_q, wdata: '0};
  assign tx_stb_o  = (state_q == ST_SEND) && tx_rdy_i;

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && done_i) addr_q <= last_addr_i;
    else if (tx_stb_o) addr_q <= addr_q - 1'b1;   // step downward
    if (state_q == ST_WAIT) tx_o <= rdata_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      count_q <= '0;
      left_q  <= '0;
    end else begin
      if (set_count_i) count_q <= read_count_i;
      case (state_q)
        ST_IDLE: if (done_i && count_q != 16'd0) begin
          left_q  <= (count_q > 16'(MEM_WORDS)) ? 16'(MEM_WORDS) : count_q;
          state_q <= ST_READ;
        end
        ST_READ: if (gnt_i) state_q <= ST_WAIT;
        ST_WAIT: state_q <= ST_SEND;                 // data valid now
        ST_SEND: if (tx_rdy_i) begin
          left_q  <= left_q - 16'd1;
          state_q <= (left_q == 16'd1) ? ST_IDLE : ST_READ;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // a stalled word stays on tx_o until ready returns
  a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == ST_SEND) && !tx_rdy_i |=> (state_q == ST_SEND) && $stable(tx_o))
    else $error("word dropped or changed while the transmitter was busy");

endmodule

// ==== la_sample_mem.sv ====
/* sample memory shared by capture and readout
   capture has fixed priority, grants are combinational
   read data is registered, one clock after the granted read
   no reset, contents are undefined until written */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_sample_mem import la_pkg::*; (
  input  logic        clk_i,
  input  logic        cap_req_i,
  input  la_mem_req_t cap_i,
  input  logic        rd_req_i,
  input  la_mem_req_t rd_i,
  output logic        cap_gnt_o,
  output logic        rd_gnt_o,
  output la_sample_t  rdata_o
);

  localparam int unsigned WORDS = 1 << `LA_DEPTH;

  la_sample_t  mem_q [WORDS];
  la_mem_req_t sel;
  logic        any_req;

  // fixed priority grant
  assign cap_gnt_o = cap_req_i;
  assign rd_gnt_o  = rd_req_i && !cap_req_i;

  assign any_req = cap_req_i || rd_req_i;
  assign sel     = cap_req_i ? cap_i : rd_i;   // winning request

  always_ff @(posedge clk_i) begin
    if (any_req) begin
      if (sel.we) begin
        mem_q[sel.addr] <= sel.wdata;
      end else begin
        rdata_o <= mem_q[sel.addr];
      end
    end
  end

  // one owner per cycle, capture is never kept waiting
  a_one_grant: assert property (@(posedge clk_i)
    cap_req_i |-> cap_gnt_o && !rd_gnt_o)
    else $error("both memory grants high");

endmodule

// ==== la_sampler.sv ====
/* input synchroniser and sample-rate divider
   data_i is taken as fully asynchronous, two flops before use
   a new divider restarts the count, a strobe every div+1 clocks */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_sampler import la_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        set_div_i,
  input  logic [23:0] div_i,
  input  la_sample_t  data_i,
  output la_sample_t  sample_o,
  output logic        sample_stb_o
);

  la_sample_t  sync_q1;
  la_sample_t  sync_q2;
  logic [23:0] div_q;
  logic [23:0] cnt_q;
  logic        tick;

  assign tick = (cnt_q == 24'd0) && !set_div_i;

  // plain double flop, no reset on data
  always_ff @(posedge clk_i) begin
    sync_q1 <= data_i;
    sync_q2 <= sync_q1;
    if (tick) sample_o <= sync_q2;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      div_q        <= '0;
      cnt_q        <= '0;
      sample_stb_o <= 1'b0;
    end else begin
      sample_stb_o <= tick;
      if (set_div_i) begin
        div_q <= div_i;
        cnt_q <= div_i;
      end else if (tick) begin
        cnt_q <= div_q;            // reload
      end else begin
        cnt_q <= cnt_q - 24'd1;
      end
    end
  end

endmodule

// ==== la_trigger.sv ====
/* single-stage trigger, mask and value compare
   only strobed samples are compared, a zero mask matches anything
   run is a one-clock pulse and disarms the trigger */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_trigger import la_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       arm_i,
  input  logic       set_mask_i,
  input  logic       set_value_i,
  input  la_sample_t arg_i,
  input  la_sample_t sample_i,
  input  logic       sample_stb_i,
  output logic       armed_o,
  output logic       run_o
);

  la_trig_cfg_t cfg_q;
  logic         hit;

  // masked compare of the current sample
  assign hit = ((sample_i ^ cfg_q.value) & cfg_q.mask) == '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q   <= '0;
      armed_o <= 1'b0;
      run_o   <= 1'b0;
    end else begin
      if (set_mask_i) cfg_q.mask <= arg_i;
      if (set_value_i) cfg_q.value <= arg_i;

      run_o <= 1'b0;
      if (arm_i) begin
        armed_o <= 1'b1;
      end else if (armed_o && sample_stb_i && hit) begin
        armed_o <= 1'b0;      // first match only
        run_o   <= 1'b1;
      end
    end
  end

  // a run always follows an armed, strobed match
  a_run_armed: assert property (@(posedge clk_i) disable iff (rst_i)
    run_o |-> $past(armed_o && sample_stb_i) && !armed_o)
    else $error("trigger fired while not armed");

endmodule

// ==== tb_clkgen.sv ====
/* clock and reset source for the testbench
   8 ns clock, reset high for the first 5 rising edges
   reset is released on a falling edge */
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  localparam time HALF = 4ns;

  initial begin
    clk_o = 1'b0;
    forever #(HALF) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;    // synchronous release
  end

endmodule
